/* hw/axi_lite_ch_pkg.sv */
package axi_lite_ch_pkg;

  // Widest ID the serializer can carry
  // The top level may use fewer bits
  localparam int unsigned ID_W = 4;

  // Address and read data widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Transaction ID as seen on the upstream side
  typedef logic [ID_W-1:0] id_t;

  // Byte address of an AW or AR beat
  typedef logic [ADDR_W-1:0] addr_t;

  // Read data of one R beat
  typedef logic [DATA_W-1:0] data_t;

  // Burst length of an AR beat, beats minus one
  typedef logic [7:0] len_t;

  // Atomic operation field of AW
  typedef logic [5:0] atop_t;

  // B and R response code
  typedef logic [1:0] resp_t;

  // Value of atop[5:4] for an ordinary write
  localparam logic [1:0] ATOP_NONE = 2'b00;

  // This atop bit set means the atomic also answers on R
  localparam int unsigned ATOP_R_RESP = 5;

endpackage

/* hw/ser_ctrl_pkg.sv */
package ser_ctrl_pkg;

  // Atomic sequencer states
  // Idle passes ordinary traffic
  // Drain waits for all outstanding responses, then sends the atomic AW
  // Execute waits for the atomic's own responses
  typedef enum logic [1:0] {
    SEQ_IDLE    = 2'b00,
    SEQ_DRAIN   = 2'b01,
    SEQ_EXECUTE = 2'b10
  } seq_state_e;

endpackage

/* hw/id_fifo.sv */
`timescale 1ns/1ps

module id_fifo #(
  parameter int unsigned Depth   = 4,
  parameter int unsigned IdWidth = 4
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    push_i,
  input  axi_lite_ch_pkg::id_t    data_i,
  input  logic                    pop_i,
  output axi_lite_ch_pkg::id_t    data_o,
  output logic                    full_o,
  output logic                    empty_o
);

  // Pointer and fill count widths
  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  typedef logic [PtrW-1:0]    ptr_t;
  typedef logic [CntW-1:0]    cnt_t;
  typedef logic [IdWidth-1:0] tag_t;

  // Storage holds only the used ID bits
  tag_t mem_q [Depth];

  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t count_q;

  logic do_push;
  logic do_pop;

  // Overflow and underflow are ignored
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign full_o  = (count_q == cnt_t'(Depth));
  assign empty_o = (count_q == '0);

  // Head entry only, a push never shows in the same cycle
  assign data_o = axi_lite_ch_pkg::id_t'(mem_q[rd_ptr_q]);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i[IdWidth-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap at Depth, which need not be a power of two
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Count moves only when exactly one side acts
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

/* hw/txn_decode.sv */
`timescale 1ns/1ps

module txn_decode (
  // AW channel
  input  logic                       slv_aw_valid_i,
  input  axi_lite_ch_pkg::id_t       slv_aw_id_i,
  input  axi_lite_ch_pkg::atop_t     slv_aw_atop_i,
  input  logic                       mst_aw_ready_i,
  output logic                       mst_aw_valid_o,
  output logic                       slv_aw_ready_o,
  // AR channel
  input  logic                       slv_ar_valid_i,
  input  axi_lite_ch_pkg::id_t       slv_ar_id_i,
  input  logic                       mst_ar_ready_i,
  output logic                       mst_ar_valid_o,
  output logic                       slv_ar_ready_o,
  // Sequencer status
  input  ser_ctrl_pkg::seq_state_e   state_i,
  input  logic                       seq_leave_i,
  // Queue status
  input  logic                       rd_full_i,
  input  logic                       wr_full_i,
  input  logic                       rd_empty_i,
  input  logic                       wr_empty_i,
  // Queue pushes
  output logic                       rd_push_o,
  output logic                       wr_push_o,
  output axi_lite_ch_pkg::id_t       rd_push_id_o,
  output logic                       atop_seen_o
);

  logic pass;
  logic is_atop;
  logic drain_go;

  // Ordinary traffic flows in idle and in the last cycle of execute
  assign pass = (state_i == ser_ctrl_pkg::SEQ_IDLE) ||
                ((state_i == ser_ctrl_pkg::SEQ_EXECUTE) && seq_leave_i);

  // Any atop[5:4] other than none marks an atomic
  assign is_atop = (slv_aw_atop_i[5:4] != axi_lite_ch_pkg::ATOP_NONE);

  // Drain is complete once nothing is outstanding
  assign drain_go = (state_i == ser_ctrl_pkg::SEQ_DRAIN) & rd_empty_i & wr_empty_i;

  // Atomic waiting at the AW head while traffic flows
  assign atop_seen_o = pass & slv_aw_valid_i & is_atop;

  always_comb begin
    mst_aw_valid_o = 1'b0;
    slv_aw_ready_o = 1'b0;
    mst_ar_valid_o = 1'b0;
    slv_ar_ready_o = 1'b0;
    rd_push_o      = 1'b0;
    wr_push_o      = 1'b0;
    rd_push_id_o   = slv_ar_id_i;

    if (pass) begin
      // AR is held while the read queue has no room
      mst_ar_valid_o = slv_ar_valid_i & ~rd_full_i;
      slv_ar_ready_o = mst_ar_ready_i & ~rd_full_i;
      rd_push_o      = mst_ar_valid_o & mst_ar_ready_i;

      // Ordinary AW passes, an atomic AW is held here
      if (!is_atop) begin
        mst_aw_valid_o = slv_aw_valid_i & ~wr_full_i;
        slv_aw_ready_o = mst_aw_ready_i & ~wr_full_i;
        wr_push_o      = mst_aw_valid_o & mst_aw_ready_i;
      end
    end else if (drain_go) begin
      // Send the held atomic AW, both queues are empty
      mst_aw_valid_o = slv_aw_valid_i;
      slv_aw_ready_o = mst_aw_ready_i;
      wr_push_o      = mst_aw_valid_o & mst_aw_ready_i;
      // Atomic with read data also waits for an R burst
      if (slv_aw_atop_i[axi_lite_ch_pkg::ATOP_R_RESP]) begin
        rd_push_id_o = slv_aw_id_i;
        rd_push_o    = mst_aw_valid_o & mst_aw_ready_i;
      end
    end
  end

endmodule

/* hw/atop_sequencer.sv */
`timescale 1ns/1ps

module atop_sequencer (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       atop_seen_i,
  input  logic                       ar_busy_i,
  input  logic                       aw_hs_i,
  input  logic                       rd_empty_i,
  input  logic                       wr_empty_i,
  input  logic                       rd_pop_i,
  input  logic                       wr_pop_i,
  output ser_ctrl_pkg::seq_state_e   state_o,
  output logic                       seq_leave_o
);

  ser_ctrl_pkg::seq_state_e state_q;
  ser_ctrl_pkg::seq_state_e state_d;

  logic rd_done;
  logic wr_done;
  logic go_drain;

  // A queue is done when empty or losing its last entry now
  assign rd_done = rd_empty_i | rd_pop_i;
  assign wr_done = wr_empty_i | wr_pop_i;

  // Last atomic response leaves this cycle
  assign seq_leave_o = (state_q == ser_ctrl_pkg::SEQ_EXECUTE) & rd_done & wr_done;

  // An AR already offered downstream must complete first
  assign go_drain = atop_seen_i & ~ar_busy_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ser_ctrl_pkg::SEQ_IDLE: begin
        if (go_drain) begin
          state_d = ser_ctrl_pkg::SEQ_DRAIN;
        end
      end
      ser_ctrl_pkg::SEQ_DRAIN: begin
        // Only the atomic AW can handshake in drain
        if (aw_hs_i) begin
          state_d = ser_ctrl_pkg::SEQ_EXECUTE;
        end
      end
      ser_ctrl_pkg::SEQ_EXECUTE: begin
        // Back to back atomics go straight to drain
        if (seq_leave_o) begin
          state_d = go_drain ? ser_ctrl_pkg::SEQ_DRAIN : ser_ctrl_pkg::SEQ_IDLE;
        end
      end
      default: state_d = ser_ctrl_pkg::SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ser_ctrl_pkg::SEQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

/* hw/id_restore.sv */
`timescale 1ns/1ps

module id_restore #(
  parameter int unsigned MaxReadTxns  = 4,
  parameter int unsigned MaxWriteTxns = 4,
  parameter int unsigned IdWidth      = 4
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // Queue pushes from decode
  input  logic                       rd_push_i,
  input  axi_lite_ch_pkg::id_t       rd_push_id_i,
  input  logic                       wr_push_i,
  input  axi_lite_ch_pkg::id_t       wr_push_id_i,
  // B channel
  input  logic                       mst_b_valid_i,
  input  axi_lite_ch_pkg::resp_t     mst_b_resp_i,
  input  logic                       slv_b_ready_i,
  output logic                       slv_b_valid_o,
  output axi_lite_ch_pkg::id_t       slv_b_id_o,
  output axi_lite_ch_pkg::resp_t     slv_b_resp_o,
  output logic                       mst_b_ready_o,
  // R channel
  input  logic                       mst_r_valid_i,
  input  axi_lite_ch_pkg::data_t     mst_r_data_i,
  input  logic                       mst_r_last_i,
  input  logic                       slv_r_ready_i,
  output logic                       slv_r_valid_o,
  output axi_lite_ch_pkg::id_t       slv_r_id_o,
  output axi_lite_ch_pkg::data_t     slv_r_data_o,
  output logic                       slv_r_last_o,
  output logic                       mst_r_ready_o,
  // Queue status
  output logic                       rd_full_o,
  output logic                       wr_full_o,
  output logic                       rd_empty_o,
  output logic                       wr_empty_o,
  output logic                       rd_pop_o,
  output logic                       wr_pop_o
);

  // B is only forwarded with an AW on record
  assign slv_b_valid_o = mst_b_valid_i & ~wr_empty_o;
  assign mst_b_ready_o = slv_b_ready_i & ~wr_empty_o;
  assign slv_b_resp_o  = mst_b_resp_i;

  // One B answers one AW
  assign wr_pop_o = slv_b_valid_o & slv_b_ready_i;

  // R is only forwarded with an AR on record
  assign slv_r_valid_o = mst_r_valid_i & ~rd_empty_o;
  assign mst_r_ready_o = slv_r_ready_i & ~rd_empty_o;
  assign slv_r_data_o  = mst_r_data_i;
  assign slv_r_last_o  = mst_r_last_i;

  // A read ID stays at the head for the whole burst
  assign rd_pop_o = slv_r_valid_o & slv_r_ready_i & mst_r_last_i;

  // Upstream IDs of reads, and of atomics that return data
  id_fifo #(
    .Depth   (MaxReadTxns),
    .IdWidth (IdWidth)
  ) i_rd_id_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (rd_push_i),
    .data_i   (rd_push_id_i),
    .pop_i    (rd_pop_o),
    .data_o   (slv_r_id_o),
    .full_o   (rd_full_o),
    .empty_o  (rd_empty_o)
  );

  // Upstream IDs of writes, atomics included
  id_fifo #(
    .Depth   (MaxWriteTxns),
    .IdWidth (IdWidth)
  ) i_wr_id_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (wr_push_i),
    .data_i   (wr_push_id_i),
    .pop_i    (wr_pop_o),
    .data_o   (slv_b_id_o),
    .full_o   (wr_full_o),
    .empty_o  (wr_empty_o)
  );

endmodule

/* hw/axi_id_serializer.sv */
`timescale 1ns/1ps

module axi_id_serializer #(
  parameter int unsigned MaxReadTxns  = 4,
  parameter int unsigned MaxWriteTxns = 4,
  parameter int unsigned IdWidth      = 4
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // Upstream AW
  input  logic                       slv_aw_valid_i,
  input  axi_lite_ch_pkg::id_t       slv_aw_id_i,
  input  axi_lite_ch_pkg::addr_t     slv_aw_addr_i,
  input  axi_lite_ch_pkg::atop_t     slv_aw_atop_i,
  output logic                       slv_aw_ready_o,
  // Upstream AR
  input  logic                       slv_ar_valid_i,
  input  axi_lite_ch_pkg::id_t       slv_ar_id_i,
  input  axi_lite_ch_pkg::addr_t     slv_ar_addr_i,
  input  axi_lite_ch_pkg::len_t      slv_ar_len_i,
  output logic                       slv_ar_ready_o,
  // Upstream B
  output logic                       slv_b_valid_o,
  output axi_lite_ch_pkg::id_t       slv_b_id_o,
  output axi_lite_ch_pkg::resp_t     slv_b_resp_o,
  input  logic                       slv_b_ready_i,
  // Upstream R
  output logic                       slv_r_valid_o,
  output axi_lite_ch_pkg::id_t       slv_r_id_o,
  output axi_lite_ch_pkg::data_t     slv_r_data_o,
  output logic                       slv_r_last_o,
  input  logic                       slv_r_ready_i,
  // Downstream AW
  output logic                       mst_aw_valid_o,
  output axi_lite_ch_pkg::id_t       mst_aw_id_o,
  output axi_lite_ch_pkg::addr_t     mst_aw_addr_o,
  output axi_lite_ch_pkg::atop_t     mst_aw_atop_o,
  input  logic                       mst_aw_ready_i,
  // Downstream AR
  output logic                       mst_ar_valid_o,
  output axi_lite_ch_pkg::id_t       mst_ar_id_o,
  output axi_lite_ch_pkg::addr_t     mst_ar_addr_o,
  output axi_lite_ch_pkg::len_t      mst_ar_len_o,
  input  logic                       mst_ar_ready_i,
  // Downstream B, its ID is always zero and is not carried
  input  logic                       mst_b_valid_i,
  input  axi_lite_ch_pkg::resp_t     mst_b_resp_i,
  output logic                       mst_b_ready_o,
  // Downstream R, its ID is always zero and is not carried
  input  logic                       mst_r_valid_i,
  input  axi_lite_ch_pkg::data_t     mst_r_data_i,
  input  logic                       mst_r_last_i,
  output logic                       mst_r_ready_o
);

  // Queue traffic
  logic                     rd_push;
  logic                     wr_push;
  axi_lite_ch_pkg::id_t     rd_push_id;
  logic                     rd_pop;
  logic                     wr_pop;
  logic                     rd_full;
  logic                     wr_full;
  logic                     rd_empty;
  logic                     wr_empty;

  // Sequencer handshake
  ser_ctrl_pkg::seq_state_e state;
  logic                     seq_leave;
  logic                     atop_seen;
  logic                     aw_hs;
  logic                     ar_busy;

  // All downstream requests share ID zero
  assign mst_aw_id_o = '0;
  assign mst_ar_id_o = '0;

  // Payload fields go straight through
  assign mst_aw_addr_o = slv_aw_addr_i;
  assign mst_aw_atop_o = slv_aw_atop_i;
  assign mst_ar_addr_o = slv_ar_addr_i;
  assign mst_ar_len_o  = slv_ar_len_i;

  assign aw_hs = mst_aw_valid_o & mst_aw_ready_i;
  // AR offered downstream but not yet taken
  assign ar_busy = mst_ar_valid_o & ~mst_ar_ready_i;

  txn_decode i_txn_decode (
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_id_i    (slv_aw_id_i),
    .slv_aw_atop_i  (slv_aw_atop_i),
    .mst_aw_ready_i (mst_aw_ready_i),
    .mst_aw_valid_o (mst_aw_valid_o),
    .slv_aw_ready_o (slv_aw_ready_o),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_id_i    (slv_ar_id_i),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_ar_valid_o (mst_ar_valid_o),
    .slv_ar_ready_o (slv_ar_ready_o),
    .state_i        (state),
    .seq_leave_i    (seq_leave),
    .rd_full_i      (rd_full),
    .wr_full_i      (wr_full),
    .rd_empty_i     (rd_empty),
    .wr_empty_i     (wr_empty),
    .rd_push_o      (rd_push),
    .wr_push_o      (wr_push),
    .rd_push_id_o   (rd_push_id),
    .atop_seen_o    (atop_seen)
  );

  atop_sequencer i_atop_sequencer (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .atop_seen_i (atop_seen),
    .ar_busy_i   (ar_busy),
    .aw_hs_i     (aw_hs),
    .rd_empty_i  (rd_empty),
    .wr_empty_i  (wr_empty),
    .rd_pop_i    (rd_pop),
    .wr_pop_i    (wr_pop),
    .state_o     (state),
    .seq_leave_o (seq_leave)
  );

  // Write queue always records the upstream AW ID
  id_restore #(
    .MaxReadTxns  (MaxReadTxns),
    .MaxWriteTxns (MaxWriteTxns),
    .IdWidth      (IdWidth)
  ) i_id_restore (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .rd_push_i     (rd_push),
    .rd_push_id_i  (rd_push_id),
    .wr_push_i     (wr_push),
    .wr_push_id_i  (slv_aw_id_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_resp_i  (mst_b_resp_i),
    .slv_b_ready_i (slv_b_ready_i),
    .slv_b_valid_o (slv_b_valid_o),
    .slv_b_id_o    (slv_b_id_o),
    .slv_b_resp_o  (slv_b_resp_o),
    .mst_b_ready_o (mst_b_ready_o),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_data_i  (mst_r_data_i),
    .mst_r_last_i  (mst_r_last_i),
    .slv_r_ready_i (slv_r_ready_i),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_id_o    (slv_r_id_o),
    .slv_r_data_o  (slv_r_data_o),
    .slv_r_last_o  (slv_r_last_o),
    .mst_r_ready_o (mst_r_ready_o),
    .rd_full_o     (rd_full),
    .wr_full_o     (wr_full),
    .rd_empty_o    (rd_empty),
    .wr_empty_o    (wr_empty),
    .rd_pop_o      (rd_pop),
    .wr_pop_o      (wr_pop)
  );

endmodule

/* verification/tb_axi_id_serializer.sv */
`timescale 1ns/1ps

module tb_axi_id_serializer;

  // Total AW plus AR beats over all traffic tests
  localparam int NUM_TXNS   = 2000;
  // About eight cycles per transaction at worst, rounded up for margin
  localparam int MAX_CYCLES = NUM_TXNS * 10;
  // Queue depths given to the DUT
  localparam int MAX_OUT    = 4;

  logic clk_i = 1'b0;
  logic arst_n_i;

  // Upstream side
  logic slv_aw_valid_i, slv_aw_ready_o;
  axi_lite_ch_pkg::id_t   slv_aw_id_i;
  axi_lite_ch_pkg::addr_t slv_aw_addr_i;
  axi_lite_ch_pkg::atop_t slv_aw_atop_i;
  logic slv_ar_valid_i, slv_ar_ready_o;
  axi_lite_ch_pkg::id_t   slv_ar_id_i;
  axi_lite_ch_pkg::addr_t slv_ar_addr_i;
  axi_lite_ch_pkg::len_t  slv_ar_len_i;
  logic slv_b_valid_o, slv_b_ready_i;
  axi_lite_ch_pkg::id_t   slv_b_id_o;
  axi_lite_ch_pkg::resp_t slv_b_resp_o;
  logic slv_r_valid_o, slv_r_last_o, slv_r_ready_i;
  axi_lite_ch_pkg::id_t   slv_r_id_o;
  axi_lite_ch_pkg::data_t slv_r_data_o;

  // Downstream side
  logic mst_aw_valid_o, mst_aw_ready_i;
  axi_lite_ch_pkg::id_t   mst_aw_id_o;
  axi_lite_ch_pkg::addr_t mst_aw_addr_o;
  axi_lite_ch_pkg::atop_t mst_aw_atop_o;
  logic mst_ar_valid_o, mst_ar_ready_i;
  axi_lite_ch_pkg::id_t   mst_ar_id_o;
  axi_lite_ch_pkg::addr_t mst_ar_addr_o;
  axi_lite_ch_pkg::len_t  mst_ar_len_o;
  logic mst_b_valid_i, mst_b_ready_o;
  axi_lite_ch_pkg::resp_t mst_b_resp_i;
  logic mst_r_valid_i, mst_r_last_i, mst_r_ready_o;
  axi_lite_ch_pkg::data_t mst_r_data_i;

  // Handshakes seen at the last sample point
  logic us_aw_hs, us_ar_hs, us_b_hs, us_r_hs;
  logic ds_aw_hs, ds_ar_hs, ds_b_hs, ds_r_hs, ds_r_last_hs;

  // Master state
  int aw_issued, ar_issued, aw_target, ar_target;
  logic bp_mode;

  // Slave model state
  int b_jobs, b_wait, r_wait, r_beat, stall_cnt;
  int r_job_q[$];

  // Reference model, expected IDs in order
  axi_lite_ch_pkg::id_t exp_b_q[$];
  axi_lite_ch_pkg::id_t exp_r_id_q[$];
  int exp_r_len_q[$];
  int us_r_beat;
  int wr_out, rd_out;
  logic atop_b_pend, atop_r_pend;
  // Atomic held upstream while earlier traffic drains
  logic drain_pend;

  // Handshake totals per channel
  int cnt_us_aw, cnt_us_ar, cnt_us_b, cnt_us_r;
  int cnt_ds_aw, cnt_ds_ar, cnt_ds_b, cnt_ds_r;

  int errors, tests, failed_tests;
  int cycle_cnt = 0;

  axi_id_serializer #(
    .MaxReadTxns  (MAX_OUT),
    .MaxWriteTxns (MAX_OUT),
    .IdWidth      (4)
  ) i_axi_id_serializer (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_id_i    (slv_aw_id_i),
    .slv_aw_addr_i  (slv_aw_addr_i),
    .slv_aw_atop_i  (slv_aw_atop_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_id_i    (slv_ar_id_i),
    .slv_ar_addr_i  (slv_ar_addr_i),
    .slv_ar_len_i   (slv_ar_len_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .slv_b_valid_o  (slv_b_valid_o),
    .slv_b_id_o     (slv_b_id_o),
    .slv_b_resp_o   (slv_b_resp_o),
    .slv_b_ready_i  (slv_b_ready_i),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_id_o     (slv_r_id_o),
    .slv_r_data_o   (slv_r_data_o),
    .slv_r_last_o   (slv_r_last_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_id_o    (mst_aw_id_o),
    .mst_aw_addr_o  (mst_aw_addr_o),
    .mst_aw_atop_o  (mst_aw_atop_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_id_o    (mst_ar_id_o),
    .mst_ar_addr_o  (mst_ar_addr_o),
    .mst_ar_len_o   (mst_ar_len_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_b_valid_i  (mst_b_valid_i),
    .mst_b_resp_i   (mst_b_resp_i),
    .mst_b_ready_o  (mst_b_ready_o),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_data_i   (mst_r_data_i),
    .mst_r_last_i   (mst_r_last_i),
    .mst_r_ready_o  (mst_r_ready_o)
  );

  // 4 ns clock period
  always #2 clk_i = ~clk_i;

  // Watchdog, ends a hung run
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("TIMEOUT: traffic did not complete within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    errors++;
  endtask

  // Upstream master and downstream slave, all on the falling edge
  task automatic drive_inputs();
    // Master holds each address beat until it is taken
    if (us_aw_hs) slv_aw_valid_i = 1'b0;
    if (!slv_aw_valid_i && aw_issued < aw_target && ($urandom % 2 == 0)) begin
      slv_aw_valid_i = 1'b1;
      slv_aw_id_i    = axi_lite_ch_pkg::id_t'($urandom);
      slv_aw_addr_i  = axi_lite_ch_pkg::addr_t'($urandom);
      // About one AW in eight is atomic, atop[5:4] never 00 then
      if ($urandom % 8 == 0) slv_aw_atop_i = {2'($urandom % 3 + 1), 4'($urandom)};
      else slv_aw_atop_i = '0;
      aw_issued++;
    end
    if (us_ar_hs) slv_ar_valid_i = 1'b0;
    if (!slv_ar_valid_i && ar_issued < ar_target && ($urandom % 2 == 0)) begin
      slv_ar_valid_i = 1'b1;
      slv_ar_id_i    = axi_lite_ch_pkg::id_t'($urandom);
      slv_ar_addr_i  = axi_lite_ch_pkg::addr_t'($urandom);
      slv_ar_len_i   = axi_lite_ch_pkg::len_t'($urandom % 4);
      ar_issued++;
    end
    slv_b_ready_i = ($urandom % 4) != 0;
    slv_r_ready_i = ($urandom % 4) != 0;

    // Slave address ready, with long stalls under back-pressure
    if (stall_cnt > 0) begin
      stall_cnt--;
      mst_aw_ready_i = 1'b0;
      mst_ar_ready_i = 1'b0;
    end else begin
      if (bp_mode && ($urandom % 16 == 0)) stall_cnt = 10;
      mst_aw_ready_i = ($urandom % 4) != 0;
      mst_ar_ready_i = ($urandom % 4) != 0;
    end

    // B answers in order after a random gap
    if (ds_b_hs) begin
      mst_b_valid_i = 1'b0;
      b_wait = int'($urandom % (bp_mode ? 8 : 3));
    end
    if (!mst_b_valid_i) begin
      if (b_wait > 0) b_wait--;
      else if (b_jobs > 0) begin
        mst_b_valid_i = 1'b1;
        mst_b_resp_i  = axi_lite_ch_pkg::resp_t'($urandom);
      end
    end

    // R bursts of len+1 beats, gap only between bursts
    if (ds_r_hs) begin
      mst_r_valid_i = 1'b0;
      if (ds_r_last_hs) begin
        r_beat = 0;
        r_wait = int'($urandom % (bp_mode ? 8 : 3));
      end else r_beat++;
    end
    if (!mst_r_valid_i) begin
      if (r_wait > 0) r_wait--;
      else if (r_job_q.size() > 0) begin
        mst_r_valid_i = 1'b1;
        mst_r_data_i  = axi_lite_ch_pkg::data_t'($urandom);
        mst_r_last_i  = (r_beat == r_job_q[0]);
      end
    end
  endtask

  // Sampled 1 ns before the rising edge, all values settled
  task automatic sample_cycle();
    logic aw_atop;
    logic aw_atop_r;
    logic ar_wait;
    logic blocked;
    logic exp_last;
    us_aw_hs = slv_aw_valid_i & slv_aw_ready_o;
    us_ar_hs = slv_ar_valid_i & slv_ar_ready_o;
    us_b_hs  = slv_b_valid_o & slv_b_ready_i;
    us_r_hs  = slv_r_valid_o & slv_r_ready_i;
    ds_aw_hs = mst_aw_valid_o & mst_aw_ready_i;
    ds_ar_hs = mst_ar_valid_o & mst_ar_ready_i;
    ds_b_hs  = mst_b_valid_i & mst_b_ready_o;
    ds_r_hs  = mst_r_valid_i & mst_r_ready_o;
    ds_r_last_hs = ds_r_hs & mst_r_last_i;
    // Classified from the AW beat the master offers
    aw_atop   = slv_aw_atop_i[5:4] != axi_lite_ch_pkg::ATOP_NONE;
    aw_atop_r = aw_atop & slv_aw_atop_i[axi_lite_ch_pkg::ATOP_R_RESP];
    // An AR offered with queue room but not taken holds off drain
    ar_wait   = slv_ar_valid_i & ~mst_ar_ready_i & (rd_out < MAX_OUT);

    // Every beat crosses both sides in the same cycle
    if (us_aw_hs != ds_aw_hs) report_error("AW handshake on one side only");
    if (us_ar_hs != ds_ar_hs) report_error("AR handshake on one side only");
    if (us_b_hs != ds_b_hs) report_error("B handshake on one side only");
    if (us_r_hs != ds_r_hs) report_error("R handshake on one side only");

    // Downstream requests carry ID zero
    if (ds_aw_hs && mst_aw_id_o != '0) report_mismatch("mst_aw_id_o", 32'(mst_aw_id_o), 0);
    if (ds_ar_hs && mst_ar_id_o != '0) report_mismatch("mst_ar_id_o", 32'(mst_ar_id_o), 0);

    // Address payload goes through unchanged
    if (ds_aw_hs && mst_aw_addr_o != slv_aw_addr_i) begin
      report_mismatch("mst_aw_addr_o", mst_aw_addr_o, slv_aw_addr_i);
    end
    if (ds_aw_hs && mst_aw_atop_o != slv_aw_atop_i) begin
      report_mismatch("mst_aw_atop_o", 32'(mst_aw_atop_o), 32'(slv_aw_atop_i));
    end
    if (ds_ar_hs && mst_ar_addr_o != slv_ar_addr_i) begin
      report_mismatch("mst_ar_addr_o", mst_ar_addr_o, slv_ar_addr_i);
    end
    if (ds_ar_hs && mst_ar_len_o != slv_ar_len_i) begin
      report_mismatch("mst_ar_len_o", 32'(mst_ar_len_o), 32'(slv_ar_len_i));
    end

    // Atomic ordering, the last response may overlap new traffic
    blocked = (atop_b_pend && !ds_b_hs) || (atop_r_pend && !ds_r_last_hs);
    if ((ds_aw_hs || ds_ar_hs) && blocked) begin
      report_error("address handshake while an atomic is unanswered");
    end
    if (ds_aw_hs && aw_atop && (wr_out != 0 || rd_out != 0)) begin
      report_error($sformatf("atomic sent with %0d writes, %0d reads open", wr_out, rd_out));
    end

    // Drain starts on the edge after an atomic waits while traffic flows
    if (drain_pend && ds_ar_hs) report_error("AR sent while an atomic drains");
    if (drain_pend) begin
      if (ds_aw_hs) drain_pend = 1'b0;
    end else if (!blocked && slv_aw_valid_i && aw_atop && !ar_wait) begin
      drain_pend = 1'b1;
    end

    if (ds_b_hs) atop_b_pend = 1'b0;
    if (ds_r_last_hs) atop_r_pend = 1'b0;
    if (ds_aw_hs && aw_atop) begin
      atop_b_pend = 1'b1;
      atop_r_pend = aw_atop_r;
    end

    // Outstanding counts at the downstream ports
    wr_out = wr_out + int'(ds_aw_hs) - int'(ds_b_hs);
    rd_out = rd_out + int'(ds_ar_hs) + int'(ds_aw_hs & aw_atop_r) - int'(ds_r_last_hs);
    if (wr_out > MAX_OUT) report_error($sformatf("%0d writes outstanding", wr_out));
    if (rd_out > MAX_OUT) report_error($sformatf("%0d reads outstanding", rd_out));

    // Slave job lists
    if (ds_b_hs) b_jobs--;
    if (ds_r_last_hs) r_job_q.delete(0);
    if (ds_aw_hs) b_jobs++;
    if (ds_aw_hs && aw_atop_r) r_job_q.push_back(0);
    if (ds_ar_hs) r_job_q.push_back(int'(mst_ar_len_o));

    // B against the oldest unanswered AW
    if (us_b_hs) begin
      if (exp_b_q.size() == 0) report_error("B with no AW outstanding");
      else begin
        if (slv_b_id_o != exp_b_q[0]) begin
          report_mismatch("slv_b_id_o", 32'(slv_b_id_o), 32'(exp_b_q[0]));
        end
        exp_b_q.delete(0);
      end
      if (slv_b_resp_o != mst_b_resp_i) begin
        report_mismatch("slv_b_resp_o", 32'(slv_b_resp_o), 32'(mst_b_resp_i));
      end
    end

    // R against the oldest unfinished AR, ID moves on after last
    if (us_r_hs) begin
      if (exp_r_id_q.size() == 0) report_error("R with no AR outstanding");
      else begin
        exp_last = (us_r_beat == exp_r_len_q[0]);
        if (slv_r_id_o != exp_r_id_q[0]) begin
          report_mismatch("slv_r_id_o", 32'(slv_r_id_o), 32'(exp_r_id_q[0]));
        end
        if (slv_r_last_o != exp_last) begin
          report_mismatch("slv_r_last_o", 32'(slv_r_last_o), 32'(exp_last));
        end
        if (exp_last) begin
          exp_r_id_q.delete(0);
          exp_r_len_q.delete(0);
          us_r_beat = 0;
        end else us_r_beat++;
      end
      if (slv_r_data_o != mst_r_data_i) begin
        report_mismatch("slv_r_data_o", slv_r_data_o, mst_r_data_i);
      end
    end

    // Record accepted requests
    if (us_aw_hs) begin
      exp_b_q.push_back(slv_aw_id_i);
      if (aw_atop_r) begin
        exp_r_id_q.push_back(slv_aw_id_i);
        exp_r_len_q.push_back(0);
      end
    end
    if (us_ar_hs) begin
      exp_r_id_q.push_back(slv_ar_id_i);
      exp_r_len_q.push_back(int'(slv_ar_len_i));
    end

    cnt_us_aw += int'(us_aw_hs);
    cnt_us_ar += int'(us_ar_hs);
    cnt_us_b  += int'(us_b_hs);
    cnt_us_r  += int'(us_r_hs);
    cnt_ds_aw += int'(ds_aw_hs);
    cnt_ds_ar += int'(ds_ar_hs);
    cnt_ds_b  += int'(ds_b_hs);
    cnt_ds_r  += int'(ds_r_hs);
  endtask

  task automatic run_cycle();
    @(negedge clk_i);
    drive_inputs();
    #1;
    sample_cycle();
  endtask

  function automatic logic traffic_done();
    return aw_issued == aw_target && ar_issued == ar_target &&
           !slv_aw_valid_i && !slv_ar_valid_i &&
           exp_b_q.size() == 0 && exp_r_id_q.size() == 0;
  endfunction

  task automatic end_test(input string name, input int start_errors);
    tests++;
    if (errors != start_errors) failed_tests++;
    $display("Test %0s finished with %0d errors", name, errors - start_errors);
  endtask

  task automatic run_traffic(input string name, input int n_each, input logic bp);
    int start_errors;
    start_errors = errors;
    bp_mode   = bp;
    aw_target += n_each;
    ar_target += n_each;
    while (!traffic_done()) run_cycle();
    bp_mode = 1'b0;
    end_test(name, start_errors);
  endtask

  initial begin
    int start_errors;
    void'($urandom(67));
    arst_n_i = 1'b0;
    slv_aw_valid_i = 1'b0;
    slv_aw_id_i = '0;
    slv_aw_addr_i = '0;
    slv_aw_atop_i = '0;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i = '0;
    slv_ar_addr_i = '0;
    slv_ar_len_i = '0;
    slv_b_ready_i = 1'b0;
    slv_r_ready_i = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_b_valid_i = 1'b0;
    mst_b_resp_i = '0;
    mst_r_valid_i = 1'b0;
    mst_r_data_i = '0;
    mst_r_last_i = 1'b0;
    {us_aw_hs, us_ar_hs, us_b_hs, us_r_hs} = '0;
    {ds_aw_hs, ds_ar_hs, ds_b_hs, ds_r_hs, ds_r_last_hs} = '0;
    {atop_b_pend, atop_r_pend, drain_pend, bp_mode} = '0;
    repeat (5) @(negedge clk_i);
    arst_n_i = 1'b1;

    // Idle outputs once out of reset
    // Responses are offered with no request on record, empty queues must block them
    start_errors = errors;
    repeat (2) begin
      @(negedge clk_i);
      mst_b_valid_i = 1'b1;
      mst_r_valid_i = 1'b1;
      mst_r_last_i  = 1'b1;
      slv_b_ready_i = 1'b1;
      slv_r_ready_i = 1'b1;
      #1;
      if (mst_aw_valid_o || mst_ar_valid_o || slv_b_valid_o || slv_r_valid_o ||
          slv_aw_ready_o || slv_ar_ready_o || mst_b_ready_o || mst_r_ready_o) begin
        report_error("valid or ready output high after reset");
      end
    end
    @(negedge clk_i);
    mst_b_valid_i = 1'b0;
    mst_r_valid_i = 1'b0;
    mst_r_last_i  = 1'b0;
    slv_b_ready_i = 1'b0;
    slv_r_ready_i = 1'b0;
    end_test("reset_idle", start_errors);

    run_traffic("mixed_traffic", NUM_TXNS / 4, 1'b0);
    run_traffic("backpressure", NUM_TXNS / 4, 1'b1);

    // No beat lost or duplicated across the run
    start_errors = errors;
    if (cnt_us_aw != cnt_ds_aw) report_mismatch("aw handshakes", cnt_ds_aw, cnt_us_aw);
    if (cnt_us_ar != cnt_ds_ar) report_mismatch("ar handshakes", cnt_ds_ar, cnt_us_ar);
    if (cnt_us_b != cnt_ds_b) report_mismatch("b handshakes", cnt_ds_b, cnt_us_b);
    if (cnt_us_r != cnt_ds_r) report_mismatch("r handshakes", cnt_ds_r, cnt_us_r);
    if (cnt_us_b != aw_target) report_mismatch("b total", cnt_us_b, aw_target);
    if (cnt_us_ar != ar_target) report_mismatch("ar total", cnt_us_ar, ar_target);
    end_test("handshake_totals", start_errors);

    $display("Summary: %0d tests, %0d failed, %0d errors, %0d cycles",
             tests, failed_tests, errors, cycle_cnt);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* vlog.f */
hw/axi_lite_ch_pkg.sv
hw/ser_ctrl_pkg.sv
hw/id_fifo.sv
hw/txn_decode.sv
hw/atop_sequencer.sv
hw/id_restore.sv
hw/axi_id_serializer.sv
verification/tb_axi_id_serializer.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, judge the result from the log

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
  --top-module tb_axi_id_serializer -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

exit 0
